// File: verilog/cache_pkg.sv
/*
 * Shared widths, types and helpers for the direct-mapped cache.
 * Every RTL block imports this package by wildcard in its module header.
 */
`default_nettype none

package cache_pkg;

    // ------------------------------------------------------------------------
    // Address split and array sizes
    // ------------------------------------------------------------------------
    localparam int ADDR_W         = 8;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_LINE = 4;
    localparam int NUM_LINES      = 4;
    localparam int OFFSET_W       = 2;                       // Byte within line
    localparam int INDEX_W        = 2;                       // Line selector
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_W         = BYTES_PER_LINE * BYTE_W;
    localparam int CNT_W          = 32;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LINE_W-1:0]   line_t;                     // Byte 0 in low bits
    typedef logic [CNT_W-1:0]    count_t;

    typedef enum logic [1:0] {
        IDLE,       // Lookup, hits answered here
        REFILL,     // Waiting for the memory port to return a line
        WRITE_MEM   // One cycle of write-through
    } ctrl_state_t;

    // Byte at offset off of a line
    function automatic byte_t get_byte(line_t line, offset_t off);
        return line[off * BYTE_W +: BYTE_W];
    endfunction

    // Same line with one byte replaced
    function automatic line_t set_byte(line_t line, offset_t off, byte_t b);
        line_t res;
        res = line;
        res[off * BYTE_W +: BYTE_W] = b;
        return res;
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic offset_t addr_offset(addr_t a);
        return a[OFFSET_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: verilog/cache_fill_if.sv
/*
 * Update path from the controller into the line store.
 * Carries a whole-line refill or a single byte write, never both at once.
 */
`default_nettype none

interface cache_fill_if import cache_pkg::*; ();

    logic  fill_en;   // Write whole line, set tag and valid
    logic  wr_en;     // Replace one byte of a present line
    addr_t addr;      // Picks line, tag and offset
    line_t line;      // Refilled line
    byte_t wdata;     // Byte for wr_en

    modport ctrl (
        output fill_en, wr_en, addr, line, wdata
    );

    modport store (
        input  fill_en, wr_en, addr, line, wdata
    );

endinterface

`default_nettype wire

// File: verilog/mem_port_if.sv
/*
 * Command and return path between the controller and the memory port.
 * refill_start and write_start are single-cycle pulses from the controller.
 */
`default_nettype none

interface mem_port_if import cache_pkg::*; ();

    logic  refill_start;  // Fetch the block holding addr
    logic  write_start;   // Write wdata to addr
    addr_t addr;
    byte_t wdata;
    line_t line;          // Assembled line, valid with line_done
    logic  line_done;     // Last refill beat, includes live memory byte

    modport ctrl (
        output refill_start, write_start, addr, wdata,
        input  line, line_done
    );

    modport port (
        input  refill_start, write_start, addr, wdata,
        output line, line_done
    );

endinterface

`default_nettype wire

// File: verilog/line_store.sv
/*
 * Valid, tag and data arrays of the cache.
 * Lookup is combinational on lookup_addr; updates land at the clock edge.
 */
`default_nettype none

module line_store import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  addr_t  lookup_addr,
    output logic   lookup_hit,
    output byte_t  lookup_byte,
    cache_fill_if.store fill
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    logic [NUM_LINES-1:0] valid_q;            // One bit per line
    tag_t                 tag_q  [NUM_LINES];
    line_t                data_q [NUM_LINES];

    index_t look_idx;
    index_t fill_idx;

    assign look_idx = addr_index(lookup_addr);
    assign fill_idx = addr_index(fill.addr);

    // ------------------------------------------------------------------------
    // Hit detection and byte read-out
    // ------------------------------------------------------------------------
    assign lookup_hit  = valid_q[look_idx] &&
                         (tag_q[look_idx] == addr_tag(lookup_addr));
    assign lookup_byte = get_byte(data_q[look_idx], addr_offset(lookup_addr));

    // Valid bits, the only state cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill.fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Tag and data, unreachable until the valid bit is set
    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            tag_q[fill_idx]  <= addr_tag(fill.addr);
            data_q[fill_idx] <= fill.line;               // Whole refilled line
        end else if (fill.wr_en) begin
            // Write hit, merge the new byte into the line
            data_q[fill_idx] <= set_byte(data_q[fill_idx],
                                         addr_offset(fill.addr),
                                         fill.wdata);
        end
    end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
/*
 * Cache controller. Accepts CPU requests in IDLE, answers read hits directly,
 * starts line refills on read misses and write-through for every write.
 * Responses and the hit/miss counters are registered.
 */
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   req_valid,
    input  logic   req_rw,              // 1 = write
    input  addr_t  req_addr,
    input  byte_t  req_wdata,
    input  logic   lookup_hit,
    input  byte_t  lookup_byte,
    output logic   ready,
    output logic   resp_valid,
    output logic   hit,
    output byte_t  resp_rdata,
    output count_t hit_count,
    output count_t miss_count,
    cache_fill_if.ctrl fill,
    mem_port_if.ctrl   mem
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    addr_t lat_addr;                    // Accepted address
    byte_t lat_wdata;                   // Accepted write byte

    logic accept;
    logic rd_miss;
    logic refill_end;

    assign accept     = (state_q == IDLE) && req_valid;
    assign rd_miss    = accept && !req_rw && !lookup_hit;
    assign refill_end = (state_q == REFILL) && mem.line_done;
    assign ready      = (state_q == IDLE);       // Low during miss or write

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (req_rw) begin
                        state_d = WRITE_MEM;     // Hit or miss, write through
                    end else if (!lookup_hit) begin
                        state_d = REFILL;
                    end
                end
            end
            REFILL:    if (mem.line_done) state_d = IDLE;
            WRITE_MEM: state_d = IDLE;           // Single write-through cycle
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_addr  <= req_addr;
            lat_wdata <= req_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Responses and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
            hit        <= 1'b0;
            resp_rdata <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            resp_valid <= 1'b0;                  // Strobe by default
            if (accept) begin
                hit <= lookup_hit;               // Held until the response
                if (lookup_hit) begin
                    hit_count <= hit_count + 1'b1;
                end else begin
                    miss_count <= miss_count + 1'b1;
                end
                if (!req_rw && lookup_hit) begin
                    resp_valid <= 1'b1;          // Read hit, next cycle
                    resp_rdata <= lookup_byte;
                end
            end
            if (refill_end) begin
                resp_valid <= 1'b1;
                resp_rdata <= get_byte(mem.line, addr_offset(lat_addr));
            end
            if (state_q == WRITE_MEM) begin
                resp_valid <= 1'b1;              // Lines up with mem_we
                resp_rdata <= '0;                // Writes return no data
            end
        end
    end

    // ------------------------------------------------------------------------
    // Line store and memory port commands
    // ------------------------------------------------------------------------
    assign fill.fill_en = refill_end;
    assign fill.wr_en   = accept && req_rw && lookup_hit;   // Write hit update
    assign fill.addr    = (state_q == REFILL) ? lat_addr : req_addr;
    assign fill.line    = mem.line;
    assign fill.wdata   = req_wdata;

    assign mem.refill_start = rd_miss;
    assign mem.write_start  = (state_q == WRITE_MEM);
    assign mem.addr         = (state_q == IDLE) ? req_addr : lat_addr;
    assign mem.wdata        = lat_wdata;

endmodule

`default_nettype wire

// File: verilog/mem_port.sv
/*
 * Memory side of the cache. Steps the address through a block on refill and
 * gathers the returning bytes into a line; registers single byte writes.
 */
`default_nettype none

module mem_port import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    mem_port_if.port mem,
    output logic  mem_we,
    output addr_t mem_addr,
    output byte_t mem_wdata,
    input  byte_t mem_rdata               // Data for last cycle's mem_addr
);

    logic              busy_q;            // Refill in progress
    logic [OFFSET_W:0] beat_q;            // Cycles since refill start
    line_t             buf_q;             // Bytes 0..2 of the refill
    offset_t           cap_off;

    // Byte n arrives on beat n+1
    assign cap_off       = offset_t'(beat_q - 1'b1);
    assign mem.line_done = busy_q && (beat_q == (OFFSET_W+1)'(BYTES_PER_LINE));
    // Last byte is taken live from memory
    assign mem.line      = set_byte(buf_q, offset_t'(BYTES_PER_LINE - 1), mem_rdata);

    // ------------------------------------------------------------------------
    // Address sequencing and write strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            beat_q   <= '0;
            mem_we   <= 1'b0;
            mem_addr <= '0;
        end else begin
            mem_we <= mem.write_start;                   // One cycle late
            if (mem.refill_start) begin
                busy_q   <= 1'b1;
                beat_q   <= '0;
                mem_addr <= {addr_tag(mem.addr), addr_index(mem.addr), offset_t'(0)};
            end else if (busy_q) begin
                beat_q <= beat_q + 1'b1;
                if (beat_q < (OFFSET_W+1)'(BYTES_PER_LINE - 1)) begin
                    mem_addr <= mem_addr + 1'b1;         // Next byte of block
                end
                if (mem.line_done) begin
                    busy_q <= 1'b0;
                end
            end else if (mem.write_start) begin
                mem_addr <= mem.addr;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (mem.write_start) begin
            mem_wdata <= mem.wdata;
        end
        if (busy_q && (beat_q != '0) && !mem.line_done) begin
            buf_q <= set_byte(buf_q, cap_off, mem_rdata);
        end
    end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
/*
 * Top level of the direct-mapped write-through cache.
 * CPU request/response strobes on one side, a registered-read memory on the other.
 */
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // CPU side
    input  logic   req_valid,
    input  logic   req_rw,
    input  addr_t  req_addr,
    input  byte_t  req_wdata,
    output logic   ready,
    output logic   resp_valid,
    output logic   hit,
    output byte_t  resp_rdata,
    output count_t hit_count,
    output count_t miss_count,

    // Memory side
    output logic   mem_we,
    output addr_t  mem_addr,
    output byte_t  mem_wdata,
    input  byte_t  mem_rdata
);

    logic  lookup_hit;
    byte_t lookup_byte;

    cache_fill_if fill_if ();
    mem_port_if   mem_if ();

    // Lookup runs on the live request address
    line_store line_store_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (req_addr),
        .lookup_hit  (lookup_hit),
        .lookup_byte (lookup_byte),
        .fill        (fill_if.store)
    );

    cache_ctrl cache_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_rw      (req_rw),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .lookup_hit  (lookup_hit),
        .lookup_byte (lookup_byte),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .hit         (hit),
        .resp_rdata  (resp_rdata),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .fill        (fill_if.ctrl),
        .mem         (mem_if.ctrl)
    );

    mem_port mem_port_i (
        .clk       (clk),
        .rst       (rst),
        .mem       (mem_if.port),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: sim/cache_properties.sv
/*
 * Concurrent checks on the cache top level ports.
 * Attached to cache_top by a bind in the testbench.
 */
`default_nettype none

module cache_properties import cache_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   ready,
    input logic   resp_valid,
    input logic   hit,
    input logic   mem_we,
    input count_t hit_count,
    input count_t miss_count
);

    // ------------------------------------------------------------------------
    // Write-through strobe
    // ------------------------------------------------------------------------
    a_we_single: assert property (@(posedge clk) disable iff (rst)
        mem_we |=> !mem_we)
        else $error("mem_we high in two consecutive cycles");

    a_we_resp: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> resp_valid)                    // Write response lines up
        else $error("mem_we without resp_valid");

    // Read miss response only after a busy period
    a_miss_busy: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !hit && !mem_we) |-> $past(!ready))
        else $error("read miss response without ready low before it");

    // Outputs parked while reset is held
    a_reset_vals: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!resp_valid && !hit && !mem_we && ready &&
                                 hit_count == '0 && miss_count == '0))
        else $error("outputs off their reset values during reset");

endmodule

`default_nettype wire

// File: sim/cache_tb.sv
/*
 * Testbench for the direct-mapped write-through cache. Models the
 * registered-read memory, runs a table of CPU requests and checks data,
 * hit flag, latency, memory traffic and the hit/miss counters.
 */
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam int NUM_TESTS = 11;
    localparam int RESET_CYC = 16;
    localparam int CYC_LIMIT = RESET_CYC + 16 * NUM_TESTS;   // Watchdog bound

    logic   clk;
    logic   rst;
    logic   req_valid;
    logic   req_rw;
    addr_t  req_addr;
    byte_t  req_wdata;
    logic   ready;
    logic   resp_valid;
    logic   hit;
    byte_t  resp_rdata;
    count_t hit_count;
    count_t miss_count;
    logic   mem_we;
    addr_t  mem_addr;
    byte_t  mem_wdata;
    byte_t  mem_rdata;

    byte_t  mem_model [256];              // External memory contents

    // Stimulus table, one column per array
    string  t_name  [NUM_TESTS];
    logic   t_rw    [NUM_TESTS];          // 1 = write
    addr_t  t_addr  [NUM_TESTS];
    byte_t  t_wdata [NUM_TESTS];
    logic   t_hit   [NUM_TESTS];
    byte_t  t_rdata [NUM_TESTS];          // Zero for writes

    int errors;
    int checks;
    int cycles;
    int exp_hits;
    int exp_misses;

    cache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_rw     (req_rw),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .ready      (ready),
        .resp_valid (resp_valid),
        .hit        (hit),
        .resp_rdata (resp_rdata),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    bind cache_top cache_properties props_i (.*);

    // ------------------------------------------------------------------------
    // Clock, memory model and watchdog
    // ------------------------------------------------------------------------
    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (mem_we) begin
            mem_model[mem_addr] <= mem_wdata;     // Write at the strobe edge
        end
        mem_rdata <= mem_model[mem_addr];         // One-cycle registered read
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout: no response within %0d clock cycles", CYC_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Memory power-up pattern
    function automatic byte_t init_byte(addr_t a);
        return a ^ 8'h5A;
    endfunction

    // Cycles from the accepting edge to resp_valid
    function automatic int expected_latency(logic rw, logic exp_hit);
        if (rw) begin
            return 2;
        end
        return exp_hit ? 1 : 6;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic set_entry(input int i, input string name, input logic rw,
                             input addr_t addr, input byte_t wdata,
                             input logic exp_hit, input byte_t exp_rdata);
        t_name[i]  = name;
        t_rw[i]    = rw;
        t_addr[i]  = addr;
        t_wdata[i] = wdata;
        t_hit[i]   = exp_hit;
        t_rdata[i] = exp_rdata;
    endtask

    // One request pulse, then wait for its response
    task automatic run_entry(input int i);
        int    n;
        addr_t base;
        base = {t_addr[i][ADDR_W-1:OFFSET_W], offset_t'(0)};
        while (!ready) begin
            @(posedge clk);
            #5;
        end
        req_valid = 1'b1;
        req_rw    = t_rw[i];
        req_addr  = t_addr[i];
        req_wdata = t_wdata[i];
        @(posedge clk);                           // Accepting edge
        #5;
        req_valid = 1'b0;
        n = 1;
        while (!resp_valid) begin
            if (!t_rw[i] && !t_hit[i] && n <= BYTES_PER_LINE) begin
                check_value(t_name[i], "mem_addr", base + addr_t'(n - 1), mem_addr);
            end
            @(posedge clk);
            #5;
            n++;
        end
        if (t_hit[i]) exp_hits++;
        else exp_misses++;
        check_value(t_name[i], "latency", expected_latency(t_rw[i], t_hit[i]), n);
        check_value(t_name[i], "hit", t_hit[i], hit);
        check_value(t_name[i], "rdata", t_rdata[i], resp_rdata);
        check_value(t_name[i], "mem_we", t_rw[i], mem_we);
        if (t_rw[i]) begin
            check_value(t_name[i], "wr_addr", t_addr[i], mem_addr);
            check_value(t_name[i], "wr_data", t_wdata[i], mem_wdata);
        end
        check_value(t_name[i], "hit_count", exp_hits, hit_count);
        check_value(t_name[i], "miss_count", exp_misses, miss_count);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int total_hits;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        exp_hits   = 0;
        exp_misses = 0;
        total_hits = 0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_rw     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        mem_rdata  = '0;
        for (int a = 0; a < 256; a++) begin
            mem_model[a] = init_byte(addr_t'(a));
        end

        //         idx name                rw    addr   wdata  hit   rdata
        set_entry(0,  "rd_miss_first",    1'b0, 8'h16, 8'h00, 1'b0, init_byte(8'h16));
        set_entry(1,  "rd_hit_off0",      1'b0, 8'h14, 8'h00, 1'b1, init_byte(8'h14));
        set_entry(2,  "rd_hit_off1",      1'b0, 8'h15, 8'h00, 1'b1, init_byte(8'h15));
        set_entry(3,  "rd_hit_off3",      1'b0, 8'h17, 8'h00, 1'b1, init_byte(8'h17));
        set_entry(4,  "wr_hit",           1'b1, 8'h15, 8'hA5, 1'b1, 8'h00);
        set_entry(5,  "rd_after_wr_hit",  1'b0, 8'h15, 8'h00, 1'b1, 8'hA5);
        set_entry(6,  "wr_miss",          1'b1, 8'h83, 8'h3C, 1'b0, 8'h00);
        set_entry(7,  "rd_after_wr_miss", 1'b0, 8'h83, 8'h00, 1'b0, 8'h3C);
        set_entry(8,  "rd_evict",         1'b0, 8'h26, 8'h00, 1'b0, init_byte(8'h26));
        set_entry(9,  "rd_reload",        1'b0, 8'h15, 8'h00, 1'b0, 8'hA5);
        set_entry(10, "rd_hit_reload",    1'b0, 8'h16, 8'h00, 1'b1, init_byte(8'h16));

        repeat (RESET_CYC) @(posedge clk);
        #5;
        rst = 1'b0;
        check_value("reset", "ready", 1'b1, ready);
        check_value("reset", "resp_valid", 1'b0, resp_valid);
        check_value("reset", "mem_we", 1'b0, mem_we);
        check_value("reset", "hit_count", 0, hit_count);
        check_value("reset", "miss_count", 0, miss_count);

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        @(posedge clk);                           // Let the last write land
        #5;

        // Written bytes must be in memory, totals must match the table
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (t_rw[i]) begin
                check_value(t_name[i], "memory", t_wdata[i], mem_model[t_addr[i]]);
            end
            if (t_hit[i]) total_hits++;
        end
        check_value("totals", "hit_count", total_hits, hit_count);
        check_value("totals", "miss_count", NUM_TESTS - total_hits, miss_count);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/cache_pkg.sv
verilog/cache_fill_if.sv
verilog/mem_port_if.sv
verilog/line_store.sv
verilog/cache_ctrl.sv
verilog/mem_port.sv
verilog/cache_top.sv
sim/cache_properties.sv
sim/cache_tb.sv

// File: Bender.yml
package:
  name: dm_cache

sources:
  # RTL in compile order
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_fill_if.sv
      - verilog/mem_port_if.sv
      - verilog/line_store.sv
      - verilog/cache_ctrl.sv
      - verilog/mem_port.sv
      - verilog/cache_top.sv

  # Testbench and bound properties
  - target: simulation
    files:
      - sim/cache_properties.sv
      - sim/cache_tb.sv
